// ==== mipsPkg.sv ====
`default_nettype none

package mipsPkg;

    localparam int dataWidth = 32;
    localparam int regAddrWidth = 5;
    localparam int imemIdxWidth = 10;

    localparam logic [5:0] opSpecial = 6'h00;
    localparam logic [5:0] opOri = 6'h0d;
    localparam logic [5:0] opLui = 6'h0f;
    localparam logic [5:0] opLw = 6'h23;
    localparam logic [5:0] opSw = 6'h2b;
    localparam logic [5:0] opBeq = 6'h04;
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSubu = 6'h23;

    typedef struct packed {
        logic [5:0] op;
        logic [regAddrWidth-1:0] rs;
        logic [regAddrWidth-1:0] rt;
        logic [regAddrWidth-1:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rFieldsT;

    typedef struct packed {
        logic [5:0] op;
        logic [regAddrWidth-1:0] rs;
        logic [regAddrWidth-1:0] rt;
        logic [15:0] imm;
    } iFieldsT;

    typedef union packed {
        rFieldsT rFields;
        iFieldsT iFields;
    } instrT;

    typedef enum logic [1:0] {aluAdd, aluSub, aluOr, aluLui} aluOpT;

    // Stages still to go, saturating at 0
    typedef logic [1:0] timeT;
    localparam timeT timeNone = 2'd3;

    typedef struct packed {
        aluOpT aluOp;
        logic useImm;
        logic zeroExt;
        logic memWrite;
        logic memToReg;
        logic regWrite;
        logic [regAddrWidth-1:0] dst;
        timeT tUseRs;
        timeT tUseRt;
        timeT tNew;
    } ctrlT;

    localparam ctrlT ctrlNop = '{aluOp: aluAdd, useImm: 1'b0, zeroExt: 1'b0,
                                 memWrite: 1'b0, memToReg: 1'b0, regWrite: 1'b0,
                                 dst: '0, tUseRs: timeNone, tUseRt: timeNone,
                                 tNew: timeNone};

    ////////////////////////////////////////
    // Pipeline payloads
    ////////////////////////////////////////
    typedef struct packed {
        logic [dataWidth-1:0] pc;
        ctrlT ctrl;
        logic [regAddrWidth-1:0] rs;
        logic [regAddrWidth-1:0] rt;
        logic [dataWidth-1:0] opA;
        logic [dataWidth-1:0] opB;
        logic [dataWidth-1:0] imm32;
    } deStageT;

    typedef struct packed {
        ctrlT ctrl;
        logic [regAddrWidth-1:0] rt;
        logic [dataWidth-1:0] aluRes;
        logic [dataWidth-1:0] storeData;
    } emStageT;

    typedef struct packed {
        ctrlT ctrl;
        logic [dataWidth-1:0] aluRes;
        logic [dataWidth-1:0] loadData;
    } mwStageT;

    typedef struct packed {
        logic en;
        logic [regAddrWidth-1:0] idx;
        logic [dataWidth-1:0] data;
    } wbT;

    typedef enum logic [1:0] {fwdNone, fwdMem, fwdWb} fwdSelT;

    ////////////////////////////////////////
    // Debug bus
    ////////////////////////////////////////
    typedef struct packed {
        logic psel;
        logic penable;
        logic pwrite;
        logic [11:0] paddr;
        logic [dataWidth-1:0] pwdata;
    } apbReqT;

    typedef struct packed {
        logic [dataWidth-1:0] prdata;
        logic pready;
        logic pslverr;
    } apbRspT;

    typedef struct packed {
        logic en;
        logic [imemIdxWidth-1:0] idx;
        logic [dataWidth-1:0] data;
    } imemWrT;

    localparam logic [11:0] addrCtrl = 12'h000;
    localparam logic [11:0] addrRegBase = 12'h100;
    localparam logic [11:0] addrImemBase = 12'h400;

    function automatic logic [dataWidth-1:0] fwdMux(
        input fwdSelT sel,
        input logic [dataWidth-1:0] regV,
        input logic [dataWidth-1:0] memV,
        input logic [dataWidth-1:0] wbV
    );
        case (sel)
            fwdMem: return memV;
            fwdWb: return wbV;
            default: return regV;
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== fetchUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetchUnit #(
    parameter int imemDepth = 256
) (
    input logic clk,
    input logic rstN,
    input logic run,
    input mipsPkg::imemWrT imemWr,
    input logic stall,
    input logic branchTaken,
    input logic [mipsPkg::dataWidth-1:0] branchTarget,
    output mipsPkg::instrT fdInstr,
    output logic [mipsPkg::dataWidth-1:0] fdPc
);

    localparam int idxW = $clog2(imemDepth);

    logic [mipsPkg::dataWidth-1:0] imem [imemDepth];
    logic [mipsPkg::dataWidth-1:0] pc;
    logic [mipsPkg::dataWidth-1:0] nextPc;

    // Host loads program words here
    always_ff @(posedge clk) begin
        if (imemWr.en) begin
            imem[imemWr.idx[idxW-1:0]] <= imemWr.data;
        end
    end

    assign nextPc = branchTaken ? branchTarget : pc + 32'd4;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= '0;
            fdInstr <= '0;
        end else if (!run) begin
            pc <= '0;
            fdInstr <= '0;
        end else if (!stall) begin
            pc <= nextPc;
            fdInstr <= imem[pc[2 +: idxW]];
            fdPc <= pc;
        end
    end

endmodule

`default_nettype wire

// ==== decodeStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
    input logic clk,
    input logic rstN,
    input mipsPkg::instrT fdInstr,
    input logic [mipsPkg::dataWidth-1:0] fdPc,
    input logic [mipsPkg::dataWidth-1:0] rdA,
    input logic [mipsPkg::dataWidth-1:0] rdB,
    input mipsPkg::fwdSelT fwdRs,
    input mipsPkg::fwdSelT fwdRt,
    input logic [mipsPkg::dataWidth-1:0] memFwd,
    input logic [mipsPkg::dataWidth-1:0] wbFwd,
    input logic stall,
    output logic [mipsPkg::regAddrWidth-1:0] rs,
    output logic [mipsPkg::regAddrWidth-1:0] rt,
    output mipsPkg::ctrlT dCtrl,
    output logic branchTaken,
    output logic [mipsPkg::dataWidth-1:0] branchTarget,
    output mipsPkg::deStageT de
);

    logic [mipsPkg::dataWidth-1:0] imm32;
    logic [mipsPkg::dataWidth-1:0] opA;
    logic [mipsPkg::dataWidth-1:0] opB;

    assign rs = fdInstr.iFields.rs;
    assign rt = fdInstr.iFields.rt;

    always_comb begin
        dCtrl = mipsPkg::ctrlNop;
        case (fdInstr.iFields.op)
            mipsPkg::opSpecial: begin
                // Zero word lands here and stays a nop
                if (fdInstr.rFields.funct == mipsPkg::fnAddu ||
                    fdInstr.rFields.funct == mipsPkg::fnSubu) begin
                    if (fdInstr.rFields.funct == mipsPkg::fnSubu) begin
                        dCtrl.aluOp = mipsPkg::aluSub;
                    end
                    dCtrl.regWrite = 1'b1;
                    dCtrl.dst = fdInstr.rFields.rd;
                    dCtrl.tUseRs = 2'd1;
                    dCtrl.tUseRt = 2'd1;
                    dCtrl.tNew = 2'd1;
                end
            end
            mipsPkg::opOri, mipsPkg::opLui: begin
                if (fdInstr.iFields.op == mipsPkg::opOri) begin
                    dCtrl.aluOp = mipsPkg::aluOr;
                    dCtrl.tUseRs = 2'd1;
                end else begin
                    dCtrl.aluOp = mipsPkg::aluLui;
                end
                dCtrl.useImm = 1'b1;
                dCtrl.zeroExt = 1'b1;
                dCtrl.regWrite = 1'b1;
                dCtrl.dst = rt;
                dCtrl.tNew = 2'd1;
            end
            mipsPkg::opLw: begin
                dCtrl.useImm = 1'b1;
                dCtrl.memToReg = 1'b1;
                dCtrl.regWrite = 1'b1;
                dCtrl.dst = rt;
                dCtrl.tUseRs = 2'd1;
                dCtrl.tNew = 2'd2;
            end
            mipsPkg::opSw: begin
                dCtrl.useImm = 1'b1;
                dCtrl.memWrite = 1'b1;
                dCtrl.tUseRs = 2'd1;
                dCtrl.tUseRt = 2'd2;
            end
            mipsPkg::opBeq: begin
                dCtrl.tUseRs = 2'd0;
                dCtrl.tUseRt = 2'd0;
            end
            default: ;
        endcase
    end

    assign imm32 = dCtrl.zeroExt ? {16'h0, fdInstr.iFields.imm}
                                 : {{16{fdInstr.iFields.imm[15]}}, fdInstr.iFields.imm};

    assign opA = mipsPkg::fwdMux(fwdRs, rdA, memFwd, wbFwd);
    assign opB = mipsPkg::fwdMux(fwdRt, rdB, memFwd, wbFwd);

    // Branch resolves here, target is relative to the delay slot
    assign branchTaken = (fdInstr.iFields.op == mipsPkg::opBeq) && (opA == opB);
    assign branchTarget = fdPc + 32'd4 + {imm32[29:0], 2'b00};

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            de.ctrl <= mipsPkg::ctrlNop;
        end else begin
            de.ctrl <= stall ? mipsPkg::ctrlNop : dCtrl;
            de.pc <= fdPc;
            de.rs <= rs;
            de.rt <= rt;
            de.opA <= opA;
            de.opB <= opB;
            de.imm32 <= imm32;
        end
    end

endmodule

`default_nettype wire

// ==== regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input logic clk,
    input logic rstN,
    input logic [mipsPkg::regAddrWidth-1:0] raA,
    input logic [mipsPkg::regAddrWidth-1:0] raB,
    input logic [mipsPkg::regAddrWidth-1:0] dbgRegIdx,
    input mipsPkg::wbT wb,
    output logic [mipsPkg::dataWidth-1:0] rdA,
    output logic [mipsPkg::dataWidth-1:0] rdB,
    output logic [mipsPkg::dataWidth-1:0] dbgRegData
);

    logic [mipsPkg::dataWidth-1:0] regs [32];

    // Same-cycle write wins over the stored value
    function automatic logic [mipsPkg::dataWidth-1:0] readReg(
        input logic [mipsPkg::regAddrWidth-1:0] idx
    );
        if (idx == '0) return '0;
        if (wb.en && wb.idx == idx) return wb.data;
        return regs[idx];
    endfunction

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            regs <= '{default: '0};
        end else if (wb.en && wb.idx != '0) begin
            regs[wb.idx] <= wb.data;
        end
    end

    always_comb begin
        rdA = readReg(raA);
        rdB = readReg(raB);
        dbgRegData = readReg(dbgRegIdx);
    end

endmodule

`default_nettype wire

// ==== executeStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module executeStage (
    input logic clk,
    input logic rstN,
    input mipsPkg::deStageT de,
    input mipsPkg::fwdSelT fwdRs,
    input mipsPkg::fwdSelT fwdRt,
    input logic [mipsPkg::dataWidth-1:0] memFwd,
    input logic [mipsPkg::dataWidth-1:0] wbFwd,
    output mipsPkg::emStageT em,
    output mipsPkg::ctrlT eCtrl
);

    logic [mipsPkg::dataWidth-1:0] srcA;
    logic [mipsPkg::dataWidth-1:0] regB;
    logic [mipsPkg::dataWidth-1:0] srcB;
    logic [mipsPkg::dataWidth-1:0] aluRes;

    assign eCtrl = de.ctrl;
    assign srcA = mipsPkg::fwdMux(fwdRs, de.opA, memFwd, wbFwd);
    assign regB = mipsPkg::fwdMux(fwdRt, de.opB, memFwd, wbFwd);
    assign srcB = de.ctrl.useImm ? de.imm32 : regB;

    always_comb begin
        case (de.ctrl.aluOp)
            mipsPkg::aluAdd: aluRes = srcA + srcB;
            mipsPkg::aluSub: aluRes = srcA - srcB;
            mipsPkg::aluOr: aluRes = srcA | srcB;
            default: aluRes = {srcB[15:0], 16'h0};
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            em.ctrl <= mipsPkg::ctrlNop;
        end else begin
            em.ctrl <= de.ctrl;
            em.rt <= de.rt;
            em.aluRes <= aluRes;
            em.storeData <= regB;
        end
    end

endmodule

`default_nettype wire

// ==== memAccess.sv ====
`timescale 1ns/1ps
`default_nettype none

module memAccess #(
    parameter int dmemDepth = 256
) (
    input logic clk,
    input logic rstN,
    input mipsPkg::emStageT em,
    input mipsPkg::fwdSelT fwdStore,
    output logic [mipsPkg::dataWidth-1:0] memFwd,
    output mipsPkg::wbT wb,
    output mipsPkg::ctrlT mCtrl,
    output mipsPkg::ctrlT wCtrl
);

    localparam int idxW = $clog2(dmemDepth);

    logic [mipsPkg::dataWidth-1:0] dmem [dmemDepth];
    logic [idxW-1:0] wordIdx;
    logic [mipsPkg::dataWidth-1:0] storeData;
    mipsPkg::mwStageT mw;

    assign memFwd = em.aluRes;
    assign mCtrl = em.ctrl;
    assign wordIdx = em.aluRes[2 +: idxW];

    // A load just ahead in writeback may still feed the store
    assign storeData = mipsPkg::fwdMux(fwdStore, em.storeData, memFwd, wb.data);

    always_ff @(posedge clk) begin
        if (em.ctrl.memWrite) begin
            dmem[wordIdx] <= storeData;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            mw.ctrl <= mipsPkg::ctrlNop;
        end else begin
            mw.ctrl <= em.ctrl;
            mw.aluRes <= em.aluRes;
            mw.loadData <= dmem[wordIdx];
        end
    end

    ////////////////////////////////////////
    // Writeback
    ////////////////////////////////////////
    assign wCtrl = mw.ctrl;
    assign wb.en = mw.ctrl.regWrite;
    assign wb.idx = mw.ctrl.dst;
    assign wb.data = mw.ctrl.memToReg ? mw.loadData : mw.aluRes;

endmodule

`default_nettype wire

// ==== hazardUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
    input mipsPkg::ctrlT dCtrl,
    input logic [mipsPkg::regAddrWidth-1:0] rs,
    input logic [mipsPkg::regAddrWidth-1:0] rt,
    input mipsPkg::ctrlT eCtrl,
    input logic [mipsPkg::regAddrWidth-1:0] eRs,
    input logic [mipsPkg::regAddrWidth-1:0] eRt,
    input mipsPkg::ctrlT mCtrl,
    input logic [mipsPkg::regAddrWidth-1:0] mRt,
    input mipsPkg::ctrlT wCtrl,
    output logic stall,
    output mipsPkg::fwdSelT fwdRsD,
    output mipsPkg::fwdSelT fwdRtD,
    output mipsPkg::fwdSelT fwdRsE,
    output mipsPkg::fwdSelT fwdRtE,
    output mipsPkg::fwdSelT fwdStore
);

    mipsPkg::timeT eNew;
    mipsPkg::timeT mNew;

    function automatic mipsPkg::timeT age(input mipsPkg::timeT t, input mipsPkg::timeT n);
        if (t == mipsPkg::timeNone) return mipsPkg::timeNone;
        return (t > n) ? mipsPkg::timeT'(t - n) : mipsPkg::timeT'(0);
    endfunction

    function automatic logic hit(
        input logic [mipsPkg::regAddrWidth-1:0] idx,
        input mipsPkg::ctrlT c
    );
        return c.regWrite && c.dst != '0 && c.dst == idx;
    endfunction

    function automatic logic mustWait(
        input logic [mipsPkg::regAddrWidth-1:0] idx,
        input mipsPkg::timeT tUse,
        input mipsPkg::ctrlT c,
        input mipsPkg::timeT cNew
    );
        return tUse != mipsPkg::timeNone && hit(idx, c) && tUse < cNew;
    endfunction

    // Youngest match decides, memory only once its value exists
    function automatic mipsPkg::fwdSelT pick(
        input logic [mipsPkg::regAddrWidth-1:0] idx,
        input mipsPkg::timeT tUse,
        input mipsPkg::ctrlT m,
        input mipsPkg::timeT mRemain
    );
        if (tUse == mipsPkg::timeNone) return mipsPkg::fwdNone;
        if (hit(idx, m)) return (mRemain == '0) ? mipsPkg::fwdMem : mipsPkg::fwdNone;
        if (hit(idx, wCtrl)) return mipsPkg::fwdWb;
        return mipsPkg::fwdNone;
    endfunction

    always_comb begin
        eNew = eCtrl.tNew;
        mNew = age(mCtrl.tNew, 2'd1);
        stall = mustWait(rs, dCtrl.tUseRs, eCtrl, eNew) ||
                mustWait(rt, dCtrl.tUseRt, eCtrl, eNew) ||
                mustWait(rs, dCtrl.tUseRs, mCtrl, mNew) ||
                mustWait(rt, dCtrl.tUseRt, mCtrl, mNew);
        fwdRsD = pick(rs, dCtrl.tUseRs, mCtrl, mNew);
        fwdRtD = pick(rt, dCtrl.tUseRt, mCtrl, mNew);
        fwdRsE = pick(eRs, age(eCtrl.tUseRs, 2'd1), mCtrl, mNew);
        fwdRtE = pick(eRt, age(eCtrl.tUseRt, 2'd1), mCtrl, mNew);
        fwdStore = pick(mRt, age(mCtrl.tUseRt, 2'd2), mipsPkg::ctrlNop, 2'd0);
    end

endmodule

`default_nettype wire

// ==== debugRegs.sv ====
`timescale 1ns/1ps
`default_nettype none

module debugRegs #(
    parameter int imemDepth = 256
) (
    input logic clk,
    input logic rstN,
    input mipsPkg::apbReqT apbReq,
    output mipsPkg::apbRspT apbRsp,
    output logic run,
    output mipsPkg::imemWrT imemWr,
    output logic [mipsPkg::regAddrWidth-1:0] dbgRegIdx,
    input logic [mipsPkg::dataWidth-1:0] dbgRegData
);

    logic access;
    logic ctrlHit;
    logic regHit;
    logic imemHit;
    logic [11:0] imemOff;

    ////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////
    assign access = apbReq.psel && apbReq.penable;
    assign imemOff = apbReq.paddr - mipsPkg::addrImemBase;

    assign ctrlHit = apbReq.paddr == mipsPkg::addrCtrl;
    assign regHit = apbReq.paddr[11:7] == mipsPkg::addrRegBase[11:7] &&
                    apbReq.paddr[1:0] == 2'b00;
    assign imemHit = apbReq.paddr >= mipsPkg::addrImemBase &&
                     apbReq.paddr[1:0] == 2'b00 && imemOff[11:2] < imemDepth;

    assign dbgRegIdx = apbReq.paddr[6:2];

    // No wait states
    assign apbRsp.pready = 1'b1;
    assign apbRsp.pslverr = access && (!(ctrlHit || regHit || imemHit) ||
                                       (apbReq.pwrite && regHit) ||
                                       (!apbReq.pwrite && imemHit));
    assign apbRsp.prdata = ctrlHit ? {31'h0, run} : regHit ? dbgRegData : '0;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            run <= 1'b0;
        end else if (access && apbReq.pwrite && ctrlHit) begin
            run <= apbReq.pwdata[0];
        end
    end

    // One-cycle pulse in the access phase
    assign imemWr.en = access && apbReq.pwrite && imemHit;
    assign imemWr.idx = imemOff[11:2];
    assign imemWr.data = apbReq.pwdata;

endmodule

`default_nettype wire

// ==== mipsTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module mipsTop #(
    parameter int imemDepth = 256,
    parameter int dmemDepth = 256
) (
    input logic clk,
    input logic rstN,
    input mipsPkg::apbReqT apbReq,
    output mipsPkg::apbRspT apbRsp
);

    logic run;
    mipsPkg::imemWrT imemWr;
    logic [mipsPkg::regAddrWidth-1:0] dbgRegIdx;
    logic [mipsPkg::dataWidth-1:0] dbgRegData;

    mipsPkg::instrT fdInstr;
    logic [mipsPkg::dataWidth-1:0] fdPc;
    logic stall;
    logic branchTaken;
    logic [mipsPkg::dataWidth-1:0] branchTarget;

    logic [mipsPkg::regAddrWidth-1:0] rs;
    logic [mipsPkg::regAddrWidth-1:0] rt;
    logic [mipsPkg::dataWidth-1:0] rdA;
    logic [mipsPkg::dataWidth-1:0] rdB;
    logic [mipsPkg::dataWidth-1:0] memFwd;

    mipsPkg::ctrlT dCtrl;
    mipsPkg::ctrlT eCtrl;
    mipsPkg::ctrlT mCtrl;
    mipsPkg::ctrlT wCtrl;
    mipsPkg::deStageT de;
    mipsPkg::emStageT em;
    mipsPkg::wbT wb;

    mipsPkg::fwdSelT fwdRsD;
    mipsPkg::fwdSelT fwdRtD;
    mipsPkg::fwdSelT fwdRsE;
    mipsPkg::fwdSelT fwdRtE;
    mipsPkg::fwdSelT fwdStore;

    debugRegs #(.imemDepth(imemDepth)) uDebug (
        .clk(clk), .rstN(rstN),
        .apbReq(apbReq), .apbRsp(apbRsp),
        .run(run), .imemWr(imemWr),
        .dbgRegIdx(dbgRegIdx), .dbgRegData(dbgRegData)
    );

    ////////////////////////////////////////
    // Pipeline
    ////////////////////////////////////////
    fetchUnit #(.imemDepth(imemDepth)) uFetch (
        .clk(clk), .rstN(rstN),
        .run(run), .imemWr(imemWr), .stall(stall),
        .branchTaken(branchTaken), .branchTarget(branchTarget),
        .fdInstr(fdInstr), .fdPc(fdPc)
    );

    decodeStage uDecode (
        .clk(clk), .rstN(rstN),
        .fdInstr(fdInstr), .fdPc(fdPc),
        .rdA(rdA), .rdB(rdB),
        .fwdRs(fwdRsD), .fwdRt(fwdRtD),
        .memFwd(memFwd), .wbFwd(wb.data), .stall(stall),
        .rs(rs), .rt(rt), .dCtrl(dCtrl),
        .branchTaken(branchTaken), .branchTarget(branchTarget),
        .de(de)
    );

    regFile uRegs (
        .clk(clk), .rstN(rstN),
        .raA(rs), .raB(rt), .dbgRegIdx(dbgRegIdx), .wb(wb),
        .rdA(rdA), .rdB(rdB), .dbgRegData(dbgRegData)
    );

    executeStage uExecute (
        .clk(clk), .rstN(rstN),
        .de(de), .fwdRs(fwdRsE), .fwdRt(fwdRtE),
        .memFwd(memFwd), .wbFwd(wb.data),
        .em(em), .eCtrl(eCtrl)
    );

    memAccess #(.dmemDepth(dmemDepth)) uMem (
        .clk(clk), .rstN(rstN),
        .em(em), .fwdStore(fwdStore),
        .memFwd(memFwd), .wb(wb),
        .mCtrl(mCtrl), .wCtrl(wCtrl)
    );

    hazardUnit uHazard (
        .dCtrl(dCtrl), .rs(rs), .rt(rt),
        .eCtrl(eCtrl), .eRs(de.rs), .eRt(de.rt),
        .mCtrl(mCtrl), .mRt(em.rt), .wCtrl(wCtrl),
        .stall(stall),
        .fwdRsD(fwdRsD), .fwdRtD(fwdRtD),
        .fwdRsE(fwdRsE), .fwdRtE(fwdRtE),
        .fwdStore(fwdStore)
    );

endmodule

`default_nettype wire

// ==== tbMips.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbMips;

    localparam int imemDepth = 256;
    localparam int dmemDepth = 256;
    // About 110 program words at ~4 cycles each, ~300 APB transfers of 3 cycles,
    // up to 4 x 200 marker polls, then generous margin
    localparam int cycleLimit = 20000;
    localparam int pollLimit = 200;
    localparam logic [31:0] haltWord = {mipsPkg::opBeq, 5'd0, 5'd0, 16'hffff};

    logic clk;
    logic rstN;
    mipsPkg::apbReqT apbReq;
    mipsPkg::apbRspT apbRsp;

    logic [31:0] prog [$];
    logic [31:0] modelRegs [32];
    logic [31:0] modelMem [dmemDepth];
    logic [31:0] lcgState;
    int cycles;

    mipsTop #(.imemDepth(imemDepth), .dmemDepth(dmemDepth)) UUT (
        .clk(clk),
        .rstN(rstN),
        .apbReq(apbReq),
        .apbRsp(apbRsp)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < cycleLimit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run went past %0d clock cycles", cycleLimit);
        $display("tests failed");
        $fatal(1, "simulation stopped");
    end

    function automatic logic [31:0] lcgNext();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic logic [31:0] rType(input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] rd, input logic [5:0] fn);
        return {mipsPkg::opSpecial, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] iType(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [11:0] regAddr(input int idx);
        return mipsPkg::addrRegBase + 12'(4 * idx);
    endfunction

    task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("** Error: %s = %h, expected %h", name, got, exp);
            $display("tests failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic emit(input logic [31:0] word);
        prog.push_back(word);
    endtask

    ////////////////////////////////////////
    // APB host
    ////////////////////////////////////////
    task automatic apbAccess(
        input logic write,
        input logic [11:0] addr,
        input logic [31:0] wdata,
        input logic expErr,
        output logic [31:0] rdata
    );
        @(negedge clk);
        apbReq.psel = 1'b1;
        apbReq.penable = 1'b0;
        apbReq.pwrite = write;
        apbReq.paddr = addr;
        apbReq.pwdata = wdata;
        @(negedge clk);
        apbReq.penable = 1'b1;
        // Response is settled mid low phase of the access cycle
        #2;
        rdata = apbRsp.prdata;
        checkEq("apbRsp.pready", {31'h0, apbRsp.pready}, 32'h1);
        checkEq("apbRsp.pslverr", {31'h0, apbRsp.pslverr}, {31'h0, expErr});
        @(negedge clk);
        apbReq.psel = 1'b0;
        apbReq.penable = 1'b0;
    endtask

    task automatic apbWrite(input logic [11:0] addr, input logic [31:0] data, input logic expErr);
        logic [31:0] discard;
        apbAccess(1'b1, addr, data, expErr, discard);
    endtask

    task automatic apbRead(input logic [11:0] addr, output logic [31:0] data, input logic expErr);
        apbAccess(1'b0, addr, 32'h0, expErr, data);
    endtask

    task automatic checkAllRegs();
        logic [31:0] rdata;
        int i;
        for (i = 0; i < 32; i++) begin
            apbRead(regAddr(i), rdata, 1'b0);
            checkEq($sformatf("apbRsp.prdata for r%0d", i), rdata, modelRegs[i]);
        end
    endtask

    ////////////////////////////////////////
    // Instruction-set model
    ////////////////////////////////////////
    task automatic runModel();
        logic [31:0] pc;
        logic [31:0] nextPc;
        logic [31:0] target;
        logic [31:0] word;
        logic [31:0] rsV;
        logic [31:0] rtV;
        logic [31:0] sext;
        logic [31:0] addr;
        logic pending;
        logic taken;
        logic done;
        int steps;
        pc = 32'h0;
        target = 32'h0;
        pending = 1'b0;
        done = 1'b0;
        steps = 0;
        while (!done) begin
            assert (pc[31:2] < prog.size() && steps < 1000) else begin
                $display("Instruction model left the program at pc %h", pc);
                $display("tests failed");
                $fatal(1, "model stopped");
            end
            word = prog[pc[31:2]];
            if (word == haltWord) begin
                done = 1'b1;
            end else begin
                rsV = modelRegs[word[25:21]];
                rtV = modelRegs[word[20:16]];
                sext = {{16{word[15]}}, word[15:0]};
                addr = rsV + sext;
                taken = 1'b0;
                case (word[31:26])
                    mipsPkg::opSpecial: begin
                        if (word[5:0] == mipsPkg::fnAddu) begin
                            modelRegs[word[15:11]] = rsV + rtV;
                        end else if (word[5:0] == mipsPkg::fnSubu) begin
                            modelRegs[word[15:11]] = rsV - rtV;
                        end
                    end
                    mipsPkg::opOri: modelRegs[word[20:16]] = rsV | {16'h0, word[15:0]};
                    mipsPkg::opLui: modelRegs[word[20:16]] = {word[15:0], 16'h0};
                    mipsPkg::opLw: modelRegs[word[20:16]] = modelMem[(addr >> 2) % dmemDepth];
                    mipsPkg::opSw: modelMem[(addr >> 2) % dmemDepth] = rtV;
                    mipsPkg::opBeq: taken = (rsV == rtV);
                    default: ;
                endcase
                modelRegs[0] = 32'h0;
                // Delay slot runs before a taken branch lands
                nextPc = pending ? target : pc + 32'd4;
                if (taken) begin
                    target = pc + 32'd4 + {sext[29:0], 2'b00};
                end
                pending = taken;
                pc = nextPc;
                steps++;
            end
        end
    endtask

    // Load, run until r31 shows the marker, stop and compare every register
    task automatic runProgram(input logic [15:0] marker);
        logic [31:0] rdata;
        int polls;
        int i;
        emit(iType(mipsPkg::opOri, 5'd0, 5'd31, marker));
        emit(haltWord);
        emit(32'h0);
        for (i = 0; i < prog.size(); i++) begin
            apbWrite(mipsPkg::addrImemBase + 12'(4 * i), prog[i], 1'b0);
        end
        runModel();
        apbWrite(mipsPkg::addrCtrl, 32'h1, 1'b0);
        apbRead(mipsPkg::addrCtrl, rdata, 1'b0);
        checkEq("apbRsp.prdata for ctrl run bit", rdata, 32'h1);
        polls = 0;
        apbRead(regAddr(31), rdata, 1'b0);
        while (rdata !== {16'h0, marker}) begin
            polls++;
            assert (polls < pollLimit) else begin
                $display("Program with marker %h never reached its halt loop", marker);
                $display("tests failed");
                $fatal(1, "program did not finish");
            end
            apbRead(regAddr(31), rdata, 1'b0);
        end
        apbWrite(mipsPkg::addrCtrl, 32'h0, 1'b0);
        apbRead(mipsPkg::addrCtrl, rdata, 1'b0);
        checkEq("apbRsp.prdata for ctrl run bit", rdata, 32'h0);
        checkAllRegs();
        prog.delete();
    endtask

    ////////////////////////////////////////
    // Programs
    ////////////////////////////////////////
    task automatic aluProgram();
        emit(iType(mipsPkg::opOri, 5'd0, 5'd1, 16'h1234));
        emit(iType(mipsPkg::opLui, 5'd0, 5'd2, 16'habcd));
        emit(iType(mipsPkg::opOri, 5'd2, 5'd2, 16'h5678));
        emit(rType(5'd1, 5'd2, 5'd3, mipsPkg::fnAddu));
        emit(rType(5'd3, 5'd1, 5'd4, mipsPkg::fnSubu));
        emit(rType(5'd3, 5'd4, 5'd0, mipsPkg::fnAddu));
        emit(iType(mipsPkg::opOri, 5'd0, 5'd0, 16'hffff));
        emit(rType(5'd0, 5'd4, 5'd5, mipsPkg::fnAddu));
        emit(rType(5'd5, 5'd5, 5'd6, mipsPkg::fnSubu));
        emit(rType(5'd6, 5'd3, 5'd7, mipsPkg::fnAddu));
        emit(iType(mipsPkg::opOri, 5'd7, 5'd8, 16'h00f0));
        emit(rType(5'd1, 5'd8, 5'd9, mipsPkg::fnSubu));
        emit(iType(mipsPkg::opLui, 5'd0, 5'd10, 16'h8000));
        emit(rType(5'd10, 5'd10, 5'd10, mipsPkg::fnAddu));
    endtask

    task automatic memoryProgram();
        emit(iType(mipsPkg::opOri, 5'd0, 5'd11, 16'h0040));
        emit(iType(mipsPkg::opOri, 5'd0, 5'd12, 16'h7777));
        emit(iType(mipsPkg::opSw, 5'd11, 5'd3, 16'h0004));
        emit(iType(mipsPkg::opSw, 5'd11, 5'd12, 16'h0000));
        emit(iType(mipsPkg::opLw, 5'd11, 5'd13, 16'h0000));
        emit(rType(5'd13, 5'd13, 5'd14, mipsPkg::fnAddu));
        emit(iType(mipsPkg::opLw, 5'd11, 5'd15, 16'h0004));
        emit(iType(mipsPkg::opSw, 5'd11, 5'd15, 16'h0008));
        emit(iType(mipsPkg::opLw, 5'd11, 5'd16, 16'h0008));
        // Load feeds a taken branch
        emit(iType(mipsPkg::opBeq, 5'd16, 5'd3, 16'h0002));
        emit(iType(mipsPkg::opOri, 5'd0, 5'd17, 16'h0001));
        emit(iType(mipsPkg::opOri, 5'd0, 5'd18, 16'h0002));
        emit(iType(mipsPkg::opOri, 5'd0, 5'd19, 16'h0003));
        emit(iType(mipsPkg::opLw, 5'd11, 5'd20, 16'h0000));
        emit(iType(mipsPkg::opBeq, 5'd20, 5'd0, 16'h0002));
        emit(iType(mipsPkg::opOri, 5'd0, 5'd21, 16'h0004));
        emit(iType(mipsPkg::opOri, 5'd0, 5'd22, 16'h0005));
    endtask

    task automatic branchProgram();
        emit(iType(mipsPkg::opOri, 5'd0, 5'd1, 16'h0005));
        emit(iType(mipsPkg::opOri, 5'd0, 5'd2, 16'h0005));
        emit(iType(mipsPkg::opBeq, 5'd1, 5'd2, 16'h0003));
        emit(rType(5'd1, 5'd2, 5'd3, mipsPkg::fnAddu));
        emit(iType(mipsPkg::opOri, 5'd0, 5'd4, 16'h0011));
        emit(iType(mipsPkg::opOri, 5'd0, 5'd5, 16'h0022));
        emit(rType(5'd1, 5'd2, 5'd6, mipsPkg::fnSubu));
        emit(iType(mipsPkg::opBeq, 5'd6, 5'd1, 16'h0002));
        emit(iType(mipsPkg::opOri, 5'd0, 5'd7, 16'h0033));
        emit(iType(mipsPkg::opOri, 5'd0, 5'd8, 16'h0044));
        // Countdown loop whose exit test depends on the subu just before it
        emit(iType(mipsPkg::opOri, 5'd0, 5'd23, 16'h0003));
        emit(iType(mipsPkg::opOri, 5'd0, 5'd25, 16'h0001));
        emit(iType(mipsPkg::opOri, 5'd0, 5'd24, 16'h0000));
        emit(rType(5'd23, 5'd25, 5'd23, mipsPkg::fnSubu));
        emit(iType(mipsPkg::opBeq, 5'd23, 5'd0, 16'h0003));
        emit(rType(5'd24, 5'd23, 5'd24, mipsPkg::fnAddu));
        emit(iType(mipsPkg::opBeq, 5'd0, 5'd0, 16'hfffc));
        emit(rType(5'd26, 5'd25, 5'd26, mipsPkg::fnAddu));
        emit(iType(mipsPkg::opOri, 5'd0, 5'd27, 16'h0055));
    endtask

    task automatic randomProgram();
        logic [31:0] fields;
        logic [31:0] choice;
        logic [4:0] rd;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [15:0] offset;
        int k;
        // Words that random loads may touch get defined first
        for (k = 0; k < 8; k++) begin
            emit(iType(mipsPkg::opSw, 5'd0, 5'(k), 16'(4 * k)));
        end
        for (k = 0; k < 40; k++) begin
            fields = lcgNext();
            choice = lcgNext();
            rd = {2'b00, fields[20:18]};
            rs = {2'b00, fields[23:21]};
            rt = {2'b00, fields[26:24]};
            offset = {11'h0, fields[29:27], 2'b00};
            case (choice[31:16] % 6)
                0: emit(rType(rs, rt, rd, mipsPkg::fnAddu));
                1: emit(rType(rs, rt, rd, mipsPkg::fnSubu));
                2: emit(iType(mipsPkg::opOri, rs, rd, choice[15:0]));
                3: emit(iType(mipsPkg::opLui, 5'd0, rd, choice[15:0]));
                4: emit(iType(mipsPkg::opLw, 5'd0, rd, offset));
                default: emit(iType(mipsPkg::opSw, 5'd0, rt, offset));
            endcase
        end
    endtask

    initial begin
        logic [31:0] rdata;
        rstN = 1'b0;
        apbReq = '0;
        lcgState = 32'h7f8ff9d3;
        modelRegs = '{default: 32'h0};
        repeat (10) @(negedge clk);
        rstN = 1'b1;

        apbRead(mipsPkg::addrCtrl, rdata, 1'b0);
        checkEq("apbRsp.prdata for ctrl after reset", rdata, 32'h0);
        checkAllRegs();

        // Bus error responses
        apbRead(12'h004, rdata, 1'b1);
        apbWrite(12'h800, 32'h1, 1'b1);
        apbWrite(regAddr(1), 32'hdeadbeef, 1'b1);
        apbRead(mipsPkg::addrImemBase, rdata, 1'b1);
        apbRead(regAddr(1), rdata, 1'b0);
        checkEq("apbRsp.prdata for r1 after rejected write", rdata, 32'h0);
        apbRead(mipsPkg::addrCtrl, rdata, 1'b0);
        checkEq("apbRsp.prdata for ctrl after rejected writes", rdata, 32'h0);

        aluProgram();
        runProgram(16'ha001);
        memoryProgram();
        runProgram(16'ha002);
        branchProgram();
        runProgram(16'ha003);
        randomProgram();
        runProgram(16'ha004);

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
mipsPkg.sv
fetchUnit.sv
decodeStage.sv
regFile.sv
executeStage.sv
memAccess.sv
hazardUnit.sv
debugRegs.sv
mipsTop.sv
tbMips.sv

// ==== Bender.yml ====
package:
  name: mips_pipeline

sources:
  - mipsPkg.sv
  - fetchUnit.sv
  - decodeStage.sv
  - regFile.sv
  - executeStage.sv
  - memAccess.sv
  - hazardUnit.sv
  - debugRegs.sv
  - mipsTop.sv
  - target: simulation
    files:
      - tbMips.sv
